/* Bender.yml */
package:
  name: sgbm_bt_cost

sources:
  - design/sgbm_cost_pkg.sv
  - design/row_sequencer.sv
  - design/sobel_prefilter.sv
  - design/disparity_window.sv
  - design/bt_channel_cost.sv
  - design/cost_combine.sv
  - design/sgbm_bt_cost_top.sv
  - target: test
    files:
      - verif/tb_sgbm_bt_cost.sv

/* build.f */
design/sgbm_cost_pkg.sv
design/row_sequencer.sv
design/sobel_prefilter.sv
design/disparity_window.sv
design/bt_channel_cost.sv
design/cost_combine.sv
design/sgbm_bt_cost_top.sv
verif/tb_sgbm_bt_cost.sv

/* design/bt_channel_cost.sv */
// payload_t must be a packed struct of val, lo, hi with three equal unsigned fields
// cost of each disparity is registered one cycle after the inputs, while i_en
`timescale 1ns/10ps

module bt_channel_cost #(
    parameter type payload_t  = sgbm_cost_pkg::pix_bt_t,
    parameter int  COST_SHIFT = 0
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       i_en,
    input  payload_t                                   i_left,
    input  payload_t [sgbm_cost_pkg::NUM_DISP-1:0]     i_window,
    output sgbm_cost_pkg::chan_vec_t                   o_cost
);
    import sgbm_cost_pkg::*;

    typedef logic [$bits(payload_t)/3-1:0]      field_t;
    // one extra bit holds the sign of a difference
    typedef logic signed [$bits(payload_t)/3:0] diff_t;

    chan_vec_t cost_next;

    function automatic diff_t sub(input field_t a, input field_t b);
        return $signed({1'b0, a}) - $signed({1'b0, b});
    endfunction

    // max(0, a, b)
    function automatic diff_t pos_max(input diff_t a, input diff_t b);
        diff_t m;
        m = (a > b) ? a : b;
        return (m < 0) ? '0 : m;
    endfunction

    // --------------------------------------------------
    // birchfield-tomasi, symmetric in left and right
    // --------------------------------------------------
    always_comb begin
        diff_t c0;
        diff_t c1;
        diff_t c_min;
        for (int d = 0; d < NUM_DISP; d++) begin
            // left value against the right interval
            c0 = pos_max(sub(i_left.val, i_window[d].hi),
                         sub(i_window[d].lo, i_left.val));
            // right value against the left interval
            c1 = pos_max(sub(i_window[d].val, i_left.hi),
                         sub(i_left.lo, i_window[d].val));
            c_min        = (c0 < c1) ? c0 : c1;
            cost_next[d] = chan_cost_t'(c_min >> COST_SHIFT);
        end
    end

    // zero costs until the first row reaches here
    always_ff @(posedge clk) begin
        if (rst) begin
            o_cost <= '0;
        end else if (i_en) begin
            o_cost <= cost_next;
        end
    end

endmodule

/* design/cost_combine.sv */
// o_cost holds its last value while o_valid is low
`timescale 1ns/10ps

module cost_combine (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_en,
    input  sgbm_cost_pkg::chan_vec_t  i_pix_cost,
    input  sgbm_cost_pkg::chan_vec_t  i_grad_cost,
    output sgbm_cost_pkg::cost_vec_t  o_cost,
    output logic                      o_valid
);
    import sgbm_cost_pkg::*;

    cost_vec_t sum_next;

    always_comb begin
        for (int d = 0; d < NUM_DISP; d++) begin
            sum_next[d] = cost_t'(i_pix_cost[d]) + cost_t'(i_grad_cost[d]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_en) begin
            o_cost <= sum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_en;
        end
    end

    // scaled pixel cost plus full gradient range bounds every sum
    for (genvar d = 0; d < NUM_DISP; d++) begin : g_range
        a_sum_max: assert property (@(posedge clk) disable iff (rst)
            o_valid |-> (o_cost[d] <= (8'hff >> PIX_SHIFT) + GRAD_MAX));
    end

endmodule

/* design/disparity_window.sv */
// entry 0 passes the incoming sample through; entry d is the sample d columns back
`timescale 1ns/10ps

module disparity_window (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                i_run,
    input  sgbm_cost_pkg::bt_sample_t                           i_sample,
    output sgbm_cost_pkg::bt_sample_t [sgbm_cost_pkg::NUM_DISP-1:0] o_window
);
    import sgbm_cost_pkg::*;

    // hist[d] holds column x-d
    bt_sample_t [NUM_DISP-1:1] hist;

    always_ff @(posedge clk) begin
        if (rst) begin
            // start as border samples
            for (int d = 1; d < NUM_DISP; d++) begin
                hist[d].pix  <= {3{pix_t'(BORDER_VAL)}};
                hist[d].grad <= {3{grad_t'(BORDER_VAL)}};
            end
        end else if (i_run) begin
            hist <= {hist[NUM_DISP-2:1], i_sample};
        end
    end

    assign o_window = {hist, i_sample};

endmodule

/* design/row_sequencer.sv */
// i_width is sampled on i_row_start; a new start is ignored while a row is running
// all outputs are levels decoded from one column counter
`timescale 1ns/10ps

module row_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_row_start,
    input  sgbm_cost_pkg::col_bits_t i_width,
    output logic                    o_run,
    output logic                    o_border,
    output logic                    o_cost_en,
    output logic                    o_row_done
);
    import sgbm_cost_pkg::*;

    logic              run;
    logic [COL_BITS:0] cnt;
    col_bits_t         width_q;
    logic [COL_BITS:0] width_ext;

    assign width_ext = {1'b0, width_q};

    // cnt = cycle - 1 while running, so column cnt is on the input
    always_ff @(posedge clk) begin
        if (rst) begin
            run     <= 1'b0;
            cnt     <= '0;
            width_q <= '0;
        end else if (i_row_start && !run) begin
            run     <= 1'b1;
            cnt     <= '0;
            width_q <= i_width;
        end else if (run) begin
            cnt <= cnt + 1'b1;
            // last cycle of the row is the last valid output
            if (cnt == width_ext + (PIPE_LAT - 1)) begin
                run <= 1'b0;
            end
        end
    end

    assign o_run      = run;
    assign o_row_done = !run;

    // filter stage works on column cnt-1; column -1 and width are masked too
    assign o_border = (cnt <= 1) || (cnt >= width_ext);

    // window full for x >= NUM_DISP-1, seen at the channel cost outputs
    // one cycle after the sample stage
    assign o_cost_en = run && (cnt >= NUM_DISP + PIPE_LAT - 2) &&
                       (cnt <= width_ext + (PIPE_LAT - 2));

    // --------------------------------------------------
    // protocol checks
    // --------------------------------------------------
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        i_row_start |-> !run);

    a_width_min: assert property (@(posedge clk) disable iff (rst)
        i_row_start |-> (i_width >= NUM_DISP + 2));

endmodule

/* design/sgbm_bt_cost_top.sv */
// one row per i_row_start, one column per clock, no back-pressure
// cost of left column x appears PIPE_LAT cycles after its input cycle
`timescale 1ns/10ps

module sgbm_bt_cost_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_row_start,
    input  sgbm_cost_pkg::col_bits_t i_width,
    input  sgbm_cost_pkg::img_col_t  i_left,
    input  sgbm_cost_pkg::img_col_t  i_right,
    output sgbm_cost_pkg::cost_vec_t o_cost,
    output logic                     o_valid,
    output logic                     o_row_done
);
    import sgbm_cost_pkg::*;

    logic                      run;
    logic                      border;
    logic                      cost_en;
    bt_sample_t                left_sample;
    bt_sample_t                right_sample;
    bt_sample_t [NUM_DISP-1:0] window;
    pix_bt_t    [NUM_DISP-1:0] win_pix;
    grad_bt_t   [NUM_DISP-1:0] win_grad;
    chan_vec_t                 pix_cost;
    chan_vec_t                 grad_cost;

    row_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .i_row_start(i_row_start),
        .i_width    (i_width),
        .o_run      (run),
        .o_border   (border),
        .o_cost_en  (cost_en),
        .o_row_done (o_row_done)
    );

    // --------------------------------------------------
    // front end, one filter per image
    // --------------------------------------------------
    sobel_prefilter u_left_filter (
        .clk     (clk),
        .rst     (rst),
        .i_run   (run),
        .i_border(border),
        .i_col   (i_left),
        .o_sample(left_sample)
    );

    sobel_prefilter u_right_filter (
        .clk     (clk),
        .rst     (rst),
        .i_run   (run),
        .i_border(border),
        .i_col   (i_right),
        .o_sample(right_sample)
    );

    disparity_window u_window (
        .clk     (clk),
        .rst     (rst),
        .i_run   (run),
        .i_sample(right_sample),
        .o_window(window)
    );

    for (genvar d = 0; d < NUM_DISP; d++) begin : g_slice
        assign win_pix[d]  = window[d].pix;
        assign win_grad[d] = window[d].grad;
    end

    // --------------------------------------------------
    // channel costs and their sum
    // --------------------------------------------------
    bt_channel_cost #(.payload_t(pix_bt_t), .COST_SHIFT(PIX_SHIFT)) u_pix_cost (
        .clk     (clk),
        .rst     (rst),
        .i_en    (run),
        .i_left  (left_sample.pix),
        .i_window(win_pix),
        .o_cost  (pix_cost)
    );

    bt_channel_cost #(.payload_t(grad_bt_t), .COST_SHIFT(0)) u_grad_cost (
        .clk     (clk),
        .rst     (rst),
        .i_en    (run),
        .i_left  (left_sample.grad),
        .i_window(win_grad),
        .o_cost  (grad_cost)
    );

    cost_combine u_combine (
        .clk        (clk),
        .rst        (rst),
        .i_en       (cost_en),
        .i_pix_cost (pix_cost),
        .i_grad_cost(grad_cost),
        .o_cost     (o_cost),
        .o_valid    (o_valid)
    );

endmodule

/* design/sgbm_cost_pkg.sv */
// constants and types shared by the cost pipeline and its testbench
// rows are scanned left to right only; i_width must lie in NUM_DISP+2 .. MAX_WIDTH-1
package sgbm_cost_pkg;

    // --------------------------------------------------
    // constants
    // --------------------------------------------------
    localparam int NUM_DISP   = 8;
    localparam int MAX_WIDTH  = 256;
    localparam int COL_BITS   = $clog2(MAX_WIDTH);
    // border columns and the zero level of the gradient share this value
    localparam int BORDER_VAL = 63;
    localparam int GRAD_MAX   = 126;
    localparam int PIX_SHIFT  = 2;
    // input cycle of column x to its cost output
    localparam int PIPE_LAT   = 6;

    // --------------------------------------------------
    // sample types
    // --------------------------------------------------
    typedef logic [7:0]          pix_t;
    typedef logic [6:0]          grad_t;
    typedef logic [COL_BITS-1:0] col_bits_t;

    // one image column of the 3-row window
    typedef struct packed {
        pix_t above;
        pix_t centre;
        pix_t below;
    } img_col_t;

    // value with its half-sample bounds
    typedef struct packed {
        pix_t val;
        pix_t lo;
        pix_t hi;
    } pix_bt_t;

    typedef struct packed {
        grad_t val;
        grad_t lo;
        grad_t hi;
    } grad_bt_t;

    typedef struct packed {
        pix_bt_t  pix;
        grad_bt_t grad;
    } bt_sample_t;

    // --------------------------------------------------
    // cost types, index d = disparity
    // --------------------------------------------------
    typedef logic [6:0]                  chan_cost_t;
    typedef chan_cost_t [NUM_DISP-1:0]   chan_vec_t;
    typedef logic [7:0]                  cost_t;
    typedef cost_t [NUM_DISP-1:0]        cost_vec_t;

endpackage

/* design/sobel_prefilter.sv */
// i_border must flag the column in the centre of the 3x3 window (one behind the input)
// 3 cycles from column x+1 on i_col to sample x on o_sample, shifting only while i_run
`timescale 1ns/10ps

module sobel_prefilter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_run,
    input  logic                      i_border,
    input  sgbm_cost_pkg::img_col_t   i_col,
    output sgbm_cost_pkg::bt_sample_t o_sample
);
    import sgbm_cost_pkg::*;

    img_col_t           col_d1;
    img_col_t           col_d2;
    logic signed [11:0] sobel_sum;
    logic signed [11:0] sobel_off;
    pix_t               pix_next;
    grad_t              grad_next;
    // [0] column x+1, [1] column x, [2] column x-1
    pix_t  [2:0]        pix_hist;
    grad_t [2:0]        grad_hist;
    pix_bt_t            pix_bt;
    pix_bt_t            grad_wide;
    bt_sample_t         sample_next;

    function automatic logic signed [11:0] col_diff(input pix_t a, input pix_t b);
        return $signed({4'b0, a}) - $signed({4'b0, b});
    endfunction

    // min and max over the value and its two floor half-sample means
    function automatic pix_bt_t half_bounds(input pix_t prev, input pix_t cur,
                                            input pix_t next);
        logic [8:0] sum_l;
        logic [8:0] sum_r;
        pix_bt_t    res;
        sum_l   = prev + cur;
        sum_r   = cur + next;
        res.val = cur;
        res.lo  = cur;
        res.hi  = cur;
        if (sum_l[8:1] < res.lo) begin
            res.lo = sum_l[8:1];
        end
        if (sum_r[8:1] < res.lo) begin
            res.lo = sum_r[8:1];
        end
        if (sum_l[8:1] > res.hi) begin
            res.hi = sum_l[8:1];
        end
        if (sum_r[8:1] > res.hi) begin
            res.hi = sum_r[8:1];
        end
        return res;
    endfunction

    // --------------------------------------------------
    // horizontal sobel on the centre column
    // --------------------------------------------------
    always_comb begin
        sobel_sum = col_diff(i_col.above, col_d2.above) +
                    (col_diff(i_col.centre, col_d2.centre) <<< 1) +
                    col_diff(i_col.below, col_d2.below);
        // gradient zero sits mid-range
        sobel_off = sobel_sum + 12'(GRAD_MAX / 2);
        if (sobel_off < 0) begin
            grad_next = '0;
        end else if (sobel_off > GRAD_MAX) begin
            grad_next = grad_t'(GRAD_MAX);
        end else begin
            grad_next = sobel_off[6:0];
        end
        pix_next = col_d1.centre;
        if (i_border) begin
            grad_next = grad_t'(BORDER_VAL);
            pix_next  = pix_t'(BORDER_VAL);
        end
    end

    always_comb begin
        pix_bt    = half_bounds(pix_hist[2], pix_hist[1], pix_hist[0]);
        grad_wide = half_bounds({1'b0, grad_hist[2]}, {1'b0, grad_hist[1]},
                                {1'b0, grad_hist[0]});
        sample_next.pix      = pix_bt;
        sample_next.grad.val = grad_wide.val[6:0];
        sample_next.grad.lo  = grad_wide.lo[6:0];
        sample_next.grad.hi  = grad_wide.hi[6:0];
    end

    always_ff @(posedge clk) begin
        if (i_run) begin
            col_d1   <= i_col;
            col_d2   <= col_d1;
            o_sample <= sample_next;
        end
    end

    // history starts out as border columns
    always_ff @(posedge clk) begin
        if (rst) begin
            pix_hist  <= {3{pix_t'(BORDER_VAL)}};
            grad_hist <= {3{grad_t'(BORDER_VAL)}};
        end else if (i_run) begin
            pix_hist  <= {pix_hist[1:0], pix_next};
            grad_hist <= {grad_hist[1:0], grad_next};
        end
    end

endmodule

/* verif/tb_sgbm_bt_cost.sv */
// runs one image row per table entry through the cost pipeline
// the model treats pixel and gradient samples outside columns 1..width-2 as 63
`timescale 1ns/10ps

module tb_sgbm_bt_cost;
    import sgbm_cost_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 3;
    localparam int NUM_TESTS  = 7;
    localparam int GRAD_ZERO  = 63;

    localparam logic [1:0] KIND_FLAT  = 2'd0;
    localparam logic [1:0] KIND_CONST = 2'd1;
    localparam logic [1:0] KIND_SHIFT = 2'd2;
    localparam logic [1:0] KIND_RAND  = 2'd3;

    // for shift rows right_val is the shift k (below NUM_DISP)
    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] width;
        logic [7:0] left_val;
        logic [7:0] right_val;
        logic       use_seed;
    } test_t;

    localparam test_t TESTS [NUM_TESTS] = '{
        '{KIND_FLAT,  8'd20, 8'd100, 8'd100, 1'b0},
        '{KIND_CONST, 8'd24, 8'd200, 8'd37,  1'b0},
        '{KIND_CONST, 8'd12, 8'd5,   8'd250, 1'b0},
        '{KIND_SHIFT, 8'd32, 8'd0,   8'd3,   1'b1},
        '{KIND_SHIFT, 8'd30, 8'd0,   8'd7,   1'b1},
        '{KIND_RAND,  8'd16, 8'd0,   8'd0,   1'b1},
        '{KIND_RAND,  8'd40, 8'd0,   8'd0,   1'b1}
    };

    logic      clk = 1'b0;
    logic      rst;
    logic      i_row_start;
    col_bits_t i_width;
    img_col_t  i_left;
    img_col_t  i_right;
    cost_vec_t o_cost;
    logic      o_valid;
    logic      o_row_done;

    img_col_t left_cols  [0:MAX_WIDTH-1];
    img_col_t right_cols [0:MAX_WIDTH-1];
    integer   seed   = 32'hb84a_60ec;
    int       errors = 0;
    int       checks = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    sgbm_bt_cost_top uut (
        .clk        (clk),
        .rst        (rst),
        .i_row_start(i_row_start),
        .i_width    (i_width),
        .i_left     (i_left),
        .i_right    (i_right),
        .o_cost     (o_cost),
        .o_valid    (o_valid),
        .o_row_done (o_row_done)
    );

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic int raw_val(input bit right, input bit grad, input int x,
                                   input int width);
        img_col_t p;
        img_col_t c;
        img_col_t n;
        int       g;
        if (x < 1 || x > width - 2) begin
            return BORDER_VAL;
        end
        p = right ? right_cols[x-1] : left_cols[x-1];
        c = right ? right_cols[x] : left_cols[x];
        n = right ? right_cols[x+1] : left_cols[x+1];
        if (!grad) begin
            return int'(c.centre);
        end
        g = int'(n.above) - int'(p.above) + 2 * (int'(n.centre) - int'(p.centre)) +
            int'(n.below) - int'(p.below) + GRAD_ZERO;
        if (g < 0) begin
            g = 0;
        end else if (g > GRAD_MAX) begin
            g = GRAD_MAX;
        end
        return g;
    endfunction

    // min or max over the sample and its two half-sample floor means
    function automatic int bound(input int prev, input int cur, input int next,
                                 input bit upper);
        int m;
        int a;
        int b;
        m = cur;
        a = (prev + cur) / 2;
        b = (cur + next) / 2;
        if (upper) begin
            m = (a > m) ? a : m;
            m = (b > m) ? b : m;
        end else begin
            m = (a < m) ? a : m;
            m = (b < m) ? b : m;
        end
        return m;
    endfunction

    function automatic int chan_cost(input int x, input int d, input bit grad,
                                     input int width);
        int u [3];
        int v [3];
        int c0;
        int c1;
        for (int k = 0; k < 3; k++) begin
            u[k] = raw_val(1'b0, grad, x + k - 1, width);
            v[k] = raw_val(1'b1, grad, x - d + k - 1, width);
        end
        c0 = 0;
        c0 = (u[1] - bound(v[0], v[1], v[2], 1'b1) > c0) ?
             u[1] - bound(v[0], v[1], v[2], 1'b1) : c0;
        c0 = (bound(v[0], v[1], v[2], 1'b0) - u[1] > c0) ?
             bound(v[0], v[1], v[2], 1'b0) - u[1] : c0;
        c1 = 0;
        c1 = (v[1] - bound(u[0], u[1], u[2], 1'b1) > c1) ?
             v[1] - bound(u[0], u[1], u[2], 1'b1) : c1;
        c1 = (bound(u[0], u[1], u[2], 1'b0) - v[1] > c1) ?
             bound(u[0], u[1], u[2], 1'b0) - v[1] : c1;
        return (c0 < c1) ? c0 : c1;
    endfunction

    function automatic cost_vec_t ref_cost(input int x, input int width);
        cost_vec_t res;
        for (int d = 0; d < NUM_DISP; d++) begin
            res[d] = cost_t'((chan_cost(x, d, 1'b0, width) >> PIX_SHIFT) +
                             chan_cost(x, d, 1'b1, width));
        end
        return res;
    endfunction

    // expected costs from the pattern alone in interior columns
    task automatic rule_expect(input test_t t, input int x, output cost_vec_t rule,
                               output cost_vec_t mask);
        int w;
        int diff;
        w    = int'(t.width);
        diff = int'(t.left_val) - int'(t.right_val);
        diff = (diff < 0) ? -diff : diff;
        rule = '0;
        mask = '0;
        for (int d = 0; d < NUM_DISP; d++) begin
            if (x - d >= 2 && x <= w - 3) begin
                if (t.kind == KIND_FLAT) begin
                    mask[d] = 8'hff;
                end else if (t.kind == KIND_CONST) begin
                    mask[d] = 8'hff;
                    rule[d] = cost_t'(diff >> PIX_SHIFT);
                end else if (t.kind == KIND_SHIFT && d == int'(t.right_val)) begin
                    mask[d] = 8'hff;
                end
            end
        end
    endtask

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            KIND_FLAT:  return "flat";
            KIND_CONST: return "const";
            KIND_SHIFT: return "shift";
            default:    return "random";
        endcase
    endfunction

    function automatic int watchdog_ns();
        int total;
        total = (RST_CYCLES + 2) * CLK_PERIOD;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += (int'(TESTS[i].width) + PIPE_LAT + 10) * CLK_PERIOD;
        end
        return total;
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_cost(input cost_vec_t got, input cost_vec_t exp,
                              input cost_vec_t mask, input string what);
        checks++;
        if ((got & mask) !== (exp & mask)) begin
            errors++;
            $display("ERROR @%0t: %s: got %h, expected %h", $time, what,
                     got & mask, exp & mask);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR @%0t: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic fill_images(input test_t t);
        logic [31:0] r;
        img_col_t    base  [0:MAX_WIDTH+NUM_DISP-1];
        img_col_t    other [0:MAX_WIDTH-1];
        int          w;
        int          k;
        w = int'(t.width);
        k = int'(t.right_val);
        for (int x = 0; x < w + NUM_DISP; x++) begin
            base[x] = '0;
            if (t.use_seed) begin
                r       = $random(seed);
                base[x] = r[23:0];
            end
        end
        for (int x = 0; x < w; x++) begin
            other[x] = '0;
            if (t.use_seed) begin
                r        = $random(seed);
                other[x] = r[23:0];
            end
        end
        for (int x = 0; x < w; x++) begin
            case (t.kind)
                KIND_SHIFT: begin
                    left_cols[x]  = base[x];
                    right_cols[x] = base[x + k];
                end
                KIND_RAND: begin
                    left_cols[x]  = base[x];
                    right_cols[x] = other[x];
                end
                default: begin
                    left_cols[x]  = {3{t.left_val}};
                    right_cols[x] = {3{t.right_val}};
                end
            endcase
        end
    endtask

    // start pulse in cycle 0 and column x in cycle x+1
    task automatic run_row(input int idx, input test_t t);
        int        w;
        int        n;
        int        x;
        int        n_valid;
        int        err_before;
        logic      exp_valid;
        cost_vec_t rule;
        cost_vec_t mask;
        w          = int'(t.width);
        n          = 0;
        n_valid    = 0;
        err_before = errors;
        fill_images(t);
        @(negedge clk);
        check_flag(o_row_done, 1'b1, "o_row_done before row start");
        i_row_start = 1'b1;
        i_width     = col_bits_t'(w);
        do begin
            @(negedge clk);
            n++;
            check_flag(o_row_done, logic'(n >= w + PIPE_LAT + 1),
                       $sformatf("o_row_done in cycle %0d", n));
            exp_valid = logic'((n >= NUM_DISP + PIPE_LAT) && (n <= w + PIPE_LAT));
            check_flag(o_valid, exp_valid, $sformatf("o_valid in cycle %0d", n));
            if (o_valid) begin
                n_valid++;
            end
            if (o_valid && exp_valid) begin
                x = n - 1 - PIPE_LAT;
                check_cost(o_cost, ref_cost(x, w), '1, $sformatf("cost of column %0d", x));
                rule_expect(t, x, rule, mask);
                if (mask != '0) begin
                    check_cost(o_cost, rule, mask, $sformatf("pattern at column %0d", x));
                end
            end
            i_row_start = 1'b0;
            if (n <= w) begin
                i_left  = left_cols[n-1];
                i_right = right_cols[n-1];
            end else begin
                i_left  = '0;
                i_right = '0;
            end
        end while (!(o_row_done === 1'b1 && n > 1));
        check_flag(logic'(n_valid == w - NUM_DISP + 1), 1'b1,
                   $sformatf("%0d valid outputs, expected %0d", n_valid, w - NUM_DISP + 1));
        $display("test %0d %s width %0d: %0d valid outputs, %s", idx, kind_name(t.kind),
                 w, n_valid, (errors == err_before) ? "ok" : "mismatches");
    endtask

    initial begin
        rst         = 1'b1;
        i_row_start = 1'b0;
        i_width     = '0;
        i_left      = '0;
        i_right     = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag(o_valid, 1'b0, "o_valid after reset");
        check_flag(o_row_done, 1'b1, "o_row_done after reset");
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(i, TESTS[i]);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns());
        $display("timeout: a row did not finish before the watchdog limit");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
